// File: common/mpt_pkg.sv
// Page-table walker shared definitions
`default_nettype none

package mpt_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////

    // Physical address of a transaction and of the memory port
    localparam int unsigned ADDR_W = 32;
    // Memory read data
    localparam int unsigned DATA_W = 32;

    // Depth of each FIFO
    // Also the bound on transactions held by the stage
    localparam int unsigned TXN_DEPTH = 4;
    // Must hold the value TXN_DEPTH itself
    localparam int unsigned USAGE_W = 3;
    // FIFO pointer width
    localparam int unsigned PTR_W = $clog2(TXN_DEPTH);

    //////////////////////////////
    // Opcodes
    //////////////////////////////

    // Access that caused the walk
    typedef enum logic [1:0] {
        ACC_LOAD  = 2'd0,
        ACC_STORE = 2'd1,
        ACC_FETCH = 2'd2
    } access_type_e;

    // Tag is access type followed by the walking bit
    localparam int unsigned TAG_W = $bits(access_type_e) + 1;
    // Grant FIFO entry is {addr, access, walking}
    localparam int unsigned GNT_FIFO_W = ADDR_W + TAG_W;
    // Valid FIFO entry is {addr, access, walking, rdata}
    localparam int unsigned VALID_FIFO_W = GNT_FIFO_W + DATA_W;

    //////////////////////////////
    // FSM states
    //////////////////////////////

    // Memory issue side
    typedef enum logic [1:0] {
        ISSUE_IDLE       = 2'd0,
        ISSUE_WAIT_GNT   = 2'd1,
        ISSUE_WAIT_USAGE = 2'd2
    } issue_state_e;

    // Response side
    typedef enum logic [1:0] {
        RESP_IDLE   = 2'd0,
        RESP_PASS   = 2'd1,
        RESP_BUFFER = 2'd2
    } resp_state_e;

endpackage : mpt_pkg

`default_nettype wire

// File: design/mem_read_stage.sv
// Memory read stage top level
`default_nettype none

module mem_read_stage import mpt_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,
    // Slave port
    input  logic              in_valid_i,
    output logic              in_ready_o,
    input  logic [ADDR_W-1:0] in_addr_i,
    input  access_type_e      in_access_i,
    input  logic              in_walking_i,
    // Master port
    output logic              out_valid_o,
    input  logic              out_ready_i,
    output logic [ADDR_W-1:0] out_addr_o,
    output access_type_e      out_access_o,
    output logic              out_walking_o,
    output logic [DATA_W-1:0] out_rdata_o,
    // Memory read port
    output logic              mem_req_o,
    output logic [ADDR_W-1:0] mem_addr_o,
    input  logic              mem_gnt_i,
    input  logic              mem_valid_i,
    input  logic [DATA_W-1:0] mem_rdata_i
);

    //////////////////////////////
    // Internal wires
    //////////////////////////////

    logic                  req_valid;
    logic                  req_ready;
    logic [ADDR_W-1:0]     req_addr;
    access_type_e          req_access;
    logic                  req_walking;

    logic                  gnt_push;
    logic                  gnt_pop;
    logic [GNT_FIFO_W-1:0] gnt_data;
    logic                  gnt_full;
    logic                  gnt_empty;
    logic [USAGE_W-1:0]    gnt_usage;

    logic [USAGE_W-1:0]    valid_usage;
    logic                  valid_full;

    // Slave side register
    stage_input_reg u_input_reg (
        .clk_i         ( clk_i        ),
        .rst_ni        ( rst_ni       ),
        .in_valid_i    ( in_valid_i   ),
        .in_addr_i     ( in_addr_i    ),
        .in_access_i   ( in_access_i  ),
        .in_walking_i  ( in_walking_i ),
        .req_ready_i   ( req_ready    ),
        .in_ready_o    ( in_ready_o   ),
        .req_valid_o   ( req_valid    ),
        .req_addr_o    ( req_addr     ),
        .req_access_o  ( req_access   ),
        .req_walking_o ( req_walking  )
    );

    // Request side
    mem_issue_ctrl u_issue_ctrl (
        .clk_i         ( clk_i       ),
        .rst_ni        ( rst_ni      ),
        .req_valid_i   ( req_valid   ),
        .req_addr_i    ( req_addr    ),
        .mem_gnt_i     ( mem_gnt_i   ),
        .gnt_usage_i   ( gnt_usage   ),
        .gnt_full_i    ( gnt_full    ),
        .valid_usage_i ( valid_usage ),
        .valid_full_i  ( valid_full  ),
        .req_ready_o   ( req_ready   ),
        .mem_req_o     ( mem_req_o   ),
        .mem_addr_o    ( mem_addr_o  ),
        .gnt_push_o    ( gnt_push    )
    );

    // Granted transactions awaiting read data
    txn_fifo #(
        .WIDTH   ( GNT_FIFO_W                           )
    ) grant_fifo (
        .clk_i   ( clk_i                                ),
        .rst_ni  ( rst_ni                               ),
        .push_i  ( gnt_push                             ),
        .data_i  ( {req_addr, req_access, req_walking}  ),
        .pop_i   ( gnt_pop                              ),
        .data_o  ( gnt_data                             ),
        .full_o  ( gnt_full                             ),
        .empty_o ( gnt_empty                            ),
        .usage_o ( gnt_usage                            )
    );

    // Response side and master port
    mem_resp_ctrl u_resp_ctrl (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .mem_valid_i   ( mem_valid_i   ),
        .mem_rdata_i   ( mem_rdata_i   ),
        .gnt_data_i    ( gnt_data      ),
        .gnt_empty_i   ( gnt_empty     ),
        .gnt_usage_i   ( gnt_usage     ),
        .gnt_push_i    ( gnt_push      ),
        .out_ready_i   ( out_ready_i   ),
        .gnt_pop_o     ( gnt_pop       ),
        .valid_usage_o ( valid_usage   ),
        .valid_full_o  ( valid_full    ),
        .out_valid_o   ( out_valid_o   ),
        .out_addr_o    ( out_addr_o    ),
        .out_access_o  ( out_access_o  ),
        .out_walking_o ( out_walking_o ),
        .out_rdata_o   ( out_rdata_o   )
    );

endmodule : mem_read_stage

`default_nettype wire

// File: design/stage_input_reg.sv
// Slave side pipeline register
`default_nettype none

module stage_input_reg import mpt_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              in_valid_i,
    input  logic [ADDR_W-1:0] in_addr_i,
    input  access_type_e      in_access_i,
    input  logic              in_walking_i,
    input  logic              req_ready_i,
    output logic              in_ready_o,
    output logic              req_valid_o,
    output logic [ADDR_W-1:0] req_addr_o,
    output access_type_e      req_access_o,
    output logic              req_walking_o
);

    logic              full_q;
    logic              load;
    logic [ADDR_W-1:0] addr_q;
    access_type_e      access_q;
    logic              walking_q;

    // Free slot, or the held entry leaves this cycle
    assign in_ready_o = !full_q || req_ready_i;
    assign load       = in_valid_i && in_ready_o;

    // Occupancy flag
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            full_q <= 1'b0;
        end else if (load) begin
            full_q <= 1'b1;
        end else if (req_ready_i) begin
            full_q <= 1'b0;
        end
    end

    // Payload
    always_ff @(posedge clk_i) begin
        if (load) begin
            addr_q    <= in_addr_i;
            access_q  <= in_access_i;
            walking_q <= in_walking_i;
        end
    end

    assign req_valid_o   = full_q;
    assign req_addr_o    = addr_q;
    assign req_access_o  = access_q;
    assign req_walking_o = walking_q;

endmodule : stage_input_reg

`default_nettype wire

// File: design/txn_fifo.sv
// Transaction FIFO
`default_nettype none

module txn_fifo import mpt_pkg::*; #(
    parameter int unsigned WIDTH = GNT_FIFO_W
) (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               push_i,
    input  logic [WIDTH-1:0]   data_i,
    input  logic               pop_i,
    output logic [WIDTH-1:0]   data_o,
    output logic               full_o,
    output logic               empty_o,
    output logic [USAGE_W-1:0] usage_o
);

    //////////////////////////////
    // Storage and pointers
    //////////////////////////////

    logic [WIDTH-1:0]   mem_q [TXN_DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [USAGE_W-1:0] usage_q;

    // Pointers and fill count
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            usage_q  <= '0;
        end else begin
            // Pointers wrap at the last slot
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(TXN_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(TXN_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Count follows push and pop together
            case ({push_i, pop_i})
                2'b10:   usage_q <= usage_q + 1'b1;
                2'b01:   usage_q <= usage_q - 1'b1;
                default: usage_q <= usage_q;
            endcase
        end
    end

    // Entry write
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    //////////////////////////////
    // Status
    //////////////////////////////

    // Head entry, registered storage only
    assign data_o  = mem_q[rd_ptr_q];
    assign full_o  = (usage_q == USAGE_W'(TXN_DEPTH));
    assign empty_o = (usage_q == '0);
    assign usage_o = usage_q;

    // Callers must respect the flags
    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_i |-> !full_o);
    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_i |-> !empty_o);

endmodule : txn_fifo

`default_nettype wire

// File: issue/mem_issue_ctrl.sv
// Memory request issue control
`default_nettype none

module mem_issue_ctrl import mpt_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               req_valid_i,
    input  logic [ADDR_W-1:0]  req_addr_i,
    input  logic               mem_gnt_i,
    input  logic [USAGE_W-1:0] gnt_usage_i,
    input  logic               gnt_full_i,
    input  logic [USAGE_W-1:0] valid_usage_i,
    input  logic               valid_full_i,
    output logic               req_ready_o,
    output logic               mem_req_o,
    output logic [ADDR_W-1:0]  mem_addr_o,
    output logic               gnt_push_o
);

    //////////////////////////////
    // Occupancy
    //////////////////////////////

    issue_state_e       state_q;
    issue_state_e       state_d;
    logic [USAGE_W:0]   stage_usage;
    logic               has_room;
    logic               room_after_push;

    // Transactions held in both FIFOs
    assign stage_usage = {1'b0, gnt_usage_i} + {1'b0, valid_usage_i};
    assign has_room    = (stage_usage < (USAGE_W + 1)'(TXN_DEPTH))
                      && !gnt_full_i && !valid_full_i;
    // One more slot still free once this grant is pushed
    assign room_after_push = ((stage_usage + 1'b1) < (USAGE_W + 1)'(TXN_DEPTH));

    //////////////////////////////
    // Issue FSM
    //////////////////////////////

    always_comb begin
        state_d     = state_q;
        mem_req_o   = 1'b0;
        gnt_push_o  = 1'b0;
        req_ready_o = 1'b0;
        unique case (state_q)
            ISSUE_IDLE: begin
                if (req_valid_i && has_room) begin
                    mem_req_o = 1'b1;
                    // Grant may already be high
                    if (mem_gnt_i) begin
                        gnt_push_o = 1'b1;
                        if (room_after_push) begin
                            req_ready_o = 1'b1;
                        end else begin
                            state_d = ISSUE_WAIT_USAGE;
                        end
                    end else begin
                        state_d = ISSUE_WAIT_GNT;
                    end
                end
            end
            ISSUE_WAIT_GNT: begin
                // Request held with the same address
                mem_req_o = req_valid_i;
                if (mem_gnt_i) begin
                    gnt_push_o = 1'b1;
                    if (room_after_push) begin
                        req_ready_o = 1'b1;
                        state_d     = ISSUE_IDLE;
                    end else begin
                        state_d = ISSUE_WAIT_USAGE;
                    end
                end
            end
            ISSUE_WAIT_USAGE: begin
                // Entry already issued, release it once space frees
                if (stage_usage < (USAGE_W + 1)'(TXN_DEPTH)) begin
                    req_ready_o = 1'b1;
                    state_d     = ISSUE_IDLE;
                end
            end
            default: begin
                state_d = ISSUE_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= ISSUE_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Address only shown alongside a request
    assign mem_addr_o = mem_req_o ? req_addr_i : '0;

    // Ungranted request keeps its address into the next cycle
    a_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mem_req_o && !mem_gnt_i) |=> (mem_req_o && $stable(mem_addr_o)));

endmodule : mem_issue_ctrl

`default_nettype wire

// File: response/mem_resp_ctrl.sv
// Memory response and output control
`default_nettype none

module mem_resp_ctrl import mpt_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  mem_valid_i,
    input  logic [DATA_W-1:0]     mem_rdata_i,
    input  logic [GNT_FIFO_W-1:0] gnt_data_i,
    input  logic                  gnt_empty_i,
    input  logic [USAGE_W-1:0]    gnt_usage_i,
    input  logic                  gnt_push_i,
    input  logic                  out_ready_i,
    output logic                  gnt_pop_o,
    output logic [USAGE_W-1:0]    valid_usage_o,
    output logic                  valid_full_o,
    output logic                  out_valid_o,
    output logic [ADDR_W-1:0]     out_addr_o,
    output access_type_e          out_access_o,
    output logic                  out_walking_o,
    output logic [DATA_W-1:0]     out_rdata_o
);

    resp_state_e             state_q;
    resp_state_e             state_d;
    logic                    valid_push;
    logic                    valid_pop;
    logic                    valid_empty;
    logic [VALID_FIFO_W-1:0] resp_entry;
    logic [VALID_FIFO_W-1:0] valid_data;
    logic [VALID_FIFO_W-1:0] out_entry;
    logic [TAG_W-1:0]        out_tag;
    logic                    gnt_drained;

    // Granted transaction joined with its read data
    assign resp_entry = {gnt_data_i, mem_rdata_i};

    // Nothing left in the grant FIFO after this cycle
    assign gnt_drained = !gnt_push_i
        && (gnt_empty_i || ((gnt_usage_i == USAGE_W'(1)) && mem_valid_i));

    //////////////////////////////
    // Response FSM
    //////////////////////////////

    always_comb begin
        state_d     = state_q;
        gnt_pop_o   = 1'b0;
        valid_push  = 1'b0;
        valid_pop   = 1'b0;
        out_valid_o = 1'b0;
        unique case (state_q)
            RESP_IDLE: begin
                // First grant into an empty stage
                if (gnt_push_i && gnt_empty_i) begin
                    state_d = RESP_PASS;
                end
            end
            RESP_PASS: begin
                if (gnt_drained) begin
                    state_d = RESP_IDLE;
                end
                if (mem_valid_i) begin
                    gnt_pop_o = 1'b1;
                    // Straight to the master port
                    if (out_ready_i) begin
                        out_valid_o = 1'b1;
                    end else begin
                        // Next stage busy so park it
                        valid_push = 1'b1;
                        state_d    = RESP_BUFFER;
                    end
                end
            end
            RESP_BUFFER: begin
                // Keep order, new responses queue behind older ones
                if (mem_valid_i) begin
                    gnt_pop_o  = 1'b1;
                    valid_push = 1'b1;
                end
                // Oldest entry offered every cycle
                out_valid_o = !valid_empty;
                if (out_ready_i && !valid_empty) begin
                    valid_pop = 1'b1;
                    if ((valid_usage_o == USAGE_W'(1)) && !mem_valid_i) begin
                        state_d = RESP_PASS;
                    end
                end
            end
            default: begin
                state_d = RESP_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= RESP_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    //////////////////////////////
    // Valid FIFO
    //////////////////////////////

    txn_fifo #(
        .WIDTH   ( VALID_FIFO_W  )
    ) valid_fifo (
        .clk_i   ( clk_i         ),
        .rst_ni  ( rst_ni        ),
        .push_i  ( valid_push    ),
        .data_i  ( resp_entry    ),
        .pop_i   ( valid_pop     ),
        .data_o  ( valid_data    ),
        .full_o  ( valid_full_o  ),
        .empty_o ( valid_empty   ),
        .usage_o ( valid_usage_o )
    );

    // Buffered head while buffering, live response otherwise
    assign out_entry = (state_q == RESP_BUFFER) ? valid_data : resp_entry;

    // Unpack {addr, access, walking, rdata}
    assign out_rdata_o   = out_entry[DATA_W-1:0];
    assign out_tag       = out_entry[DATA_W +: TAG_W];
    assign out_walking_o = out_tag[0];
    assign out_access_o  = access_type_e'(out_tag[TAG_W-1:1]);
    assign out_addr_o    = out_entry[VALID_FIFO_W-1 -: ADDR_W];

    // Every response belongs to a granted request
    a_valid_has_grant: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_valid_i |-> !gnt_empty_i);

endmodule : mem_resp_ctrl

`default_nettype wire

// File: sources.f
common/mpt_pkg.sv
design/txn_fifo.sv
design/stage_input_reg.sv
issue/mem_issue_ctrl.sv
response/mem_resp_ctrl.sv
design/mem_read_stage.sv
tests/tb_clock_gen.sv
tests/tb_mem_model.sv
tests/tb_mem_read_stage.sv

// File: tests/tb_clock_gen.sv
// Testbench clock and reset
`default_nettype none

module tb_clock_gen #(
    parameter int unsigned PERIOD     = 8,
    parameter int unsigned RST_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_no
);

    // Free running clock, low at time zero
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD / 2) clk_o = ~clk_o;
        end
    end

    // Reset held over the first rising edges, released on a falling edge
    initial begin
        rst_no = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule : tb_clock_gen

`default_nettype wire

// File: tests/tb_mem_model.sv
// Behavioral read memory
`default_nettype none

module tb_mem_model import mpt_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              always_gnt_i,
    input  logic              mem_req_i,
    input  logic [ADDR_W-1:0] mem_addr_i,
    output logic              mem_gnt_o,
    output logic              mem_valid_o,
    output logic [DATA_W-1:0] mem_rdata_o
);

    integer            seed        = 24;
    int unsigned       cycle       = 0;
    int unsigned       last_due    = 0;
    int unsigned       gnt_wait    = 0;
    int unsigned       resp_delay  = 1;
    bit                pending     = 1'b0;
    bit                accepted    = 1'b0;
    bit                always_mode = 1'b0;
    // Accepted reads in order, with the cycle their data is due
    logic [ADDR_W-1:0] addr_q [$];
    int unsigned       due_q [$];

    initial begin
        mem_gnt_o   = 1'b0;
        mem_valid_o = 1'b0;
        mem_rdata_o = '0;
    end

    //////////////////////////////
    // Edge bookkeeping
    //////////////////////////////

    always @(posedge clk_i) begin
        int unsigned due;
        if (!rst_ni) begin
            cycle       = 0;
            last_due    = 0;
            accepted    = 1'b0;
            always_mode = 1'b0;
            addr_q.delete();
            due_q.delete();
        end else begin
            cycle       = cycle + 1;
            // Mode takes effect one cycle after the testbench sets it
            always_mode = always_gnt_i;
            // Response just delivered
            if (mem_valid_o) begin
                void'(addr_q.pop_front());
                void'(due_q.pop_front());
            end
            accepted = mem_req_i && mem_gnt_o;
            if (accepted) begin
                due = cycle + resp_delay;
                // One response per cycle, never overtaking
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                addr_q.push_back(mem_addr_i);
                due_q.push_back(due);
            end
        end
    end

    //////////////////////////////
    // Outputs for the next cycle
    //////////////////////////////

    always @(negedge clk_i) begin
        if (!rst_ni) begin
            pending     = 1'b0;
            gnt_wait    = 0;
            mem_gnt_o   = 1'b0;
            mem_valid_o = 1'b0;
            mem_rdata_o = '0;
        end else begin
            if (accepted) begin
                pending = 1'b0;
            end
            if (always_mode) begin
                mem_gnt_o = 1'b1;
            end else if (!mem_req_i) begin
                pending   = 1'b0;
                mem_gnt_o = 1'b0;
            end else if (!pending) begin
                // Fresh request, grant after 0 to 2 cycles
                pending   = 1'b1;
                gnt_wait  = $unsigned($random(seed)) % 3;
                mem_gnt_o = (gnt_wait == 0);
            end else begin
                if (gnt_wait > 0) begin
                    gnt_wait = gnt_wait - 1;
                end
                mem_gnt_o = (gnt_wait == 0);
            end
            // Data 1 to 3 cycles after the grant
            if (mem_gnt_o) begin
                resp_delay = 1 + ($unsigned($random(seed)) % 3);
            end
            // Read data is the inverted address
            if ((due_q.size() > 0) && (due_q[0] == cycle + 1)) begin
                mem_valid_o = 1'b1;
                mem_rdata_o = ~addr_q[0];
            end else begin
                mem_valid_o = 1'b0;
                mem_rdata_o = '0;
            end
        end
    end

endmodule : tb_mem_model

`default_nettype wire

// File: tests/tb_mem_read_stage.sv
// Memory read stage testbench
`default_nettype none

module tb_mem_read_stage import mpt_pkg::*; ();

    localparam int unsigned NUM_TXN       = 16;
    localparam int unsigned CLK_PERIOD    = 8;
    localparam int unsigned WATCHDOG_TIME = NUM_TXN * 40 * CLK_PERIOD;

    logic              clk;
    logic              rst_n;
    logic              always_gnt;
    logic              in_valid;
    logic              in_ready;
    logic [ADDR_W-1:0] in_addr;
    access_type_e      in_access;
    logic              in_walking;
    logic              out_valid;
    logic              out_ready;
    logic [ADDR_W-1:0] out_addr;
    access_type_e      out_access;
    logic              out_walking;
    logic [DATA_W-1:0] out_rdata;
    logic              mem_req;
    logic [ADDR_W-1:0] mem_addr;
    logic              mem_gnt;
    logic              mem_valid;
    logic [DATA_W-1:0] mem_rdata;

    // Stimulus table with one column per array
    logic [ADDR_W-1:0] tbl_addr  [NUM_TXN];
    access_type_e      tbl_acc   [NUM_TXN];
    logic              tbl_walk  [NUM_TXN];
    int unsigned       tbl_stall [NUM_TXN];
    logic              tbl_agnt  [NUM_TXN];

    // Expected {addr, access, walking} in input order
    logic [ADDR_W+2:0]     exp_q [$];
    int                    out_count  = 0;
    int                    gnt_count  = 0;
    int                    b2b_count  = 0;
    int unsigned           stall_left = 0;
    bit                    prev_gnt   = 1'b0;
    bit                    addr_wait  = 1'b0;
    bit                    out_hold   = 1'b0;
    logic [ADDR_W-1:0]     held_addr;
    logic [ADDR_W+DATA_W+2:0] held_out;

    tb_clock_gen #(
        .PERIOD     ( CLK_PERIOD ),
        .RST_CYCLES ( 2          )
    ) clock_gen (
        .clk_o  ( clk   ),
        .rst_no ( rst_n )
    );

    tb_mem_model mem_model (
        .clk_i        ( clk        ),
        .rst_ni       ( rst_n      ),
        .always_gnt_i ( always_gnt ),
        .mem_req_i    ( mem_req    ),
        .mem_addr_i   ( mem_addr   ),
        .mem_gnt_o    ( mem_gnt    ),
        .mem_valid_o  ( mem_valid  ),
        .mem_rdata_o  ( mem_rdata  )
    );

    mem_read_stage uut (
        .clk_i         ( clk         ),
        .rst_ni        ( rst_n       ),
        .in_valid_i    ( in_valid    ),
        .in_ready_o    ( in_ready    ),
        .in_addr_i     ( in_addr     ),
        .in_access_i   ( in_access   ),
        .in_walking_i  ( in_walking  ),
        .out_valid_o   ( out_valid   ),
        .out_ready_i   ( out_ready   ),
        .out_addr_o    ( out_addr    ),
        .out_access_o  ( out_access  ),
        .out_walking_o ( out_walking ),
        .out_rdata_o   ( out_rdata   ),
        .mem_req_o     ( mem_req     ),
        .mem_addr_o    ( mem_addr    ),
        .mem_gnt_i     ( mem_gnt     ),
        .mem_valid_i   ( mem_valid   ),
        .mem_rdata_i   ( mem_rdata   )
    );

    task automatic report_failure(input string msg);
        $display("error at time %0t: %s", $time, msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic set_entry(input int unsigned idx, input logic [ADDR_W-1:0] addr,
                             input access_type_e acc, input logic walk,
                             input int unsigned stall, input logic agnt);
        tbl_addr[idx]  = addr;
        tbl_acc[idx]   = acc;
        tbl_walk[idx]  = walk;
        tbl_stall[idx] = stall;
        tbl_agnt[idx]  = agnt;
    endtask

    // Address, access, walking, output stall cycles, always grant
    task automatic fill_table();
        set_entry(0,  32'h0000_1000, ACC_LOAD,  1'b0, 0, 1'b0);
        set_entry(1,  32'h0000_1008, ACC_STORE, 1'b1, 3, 1'b0);
        set_entry(2,  32'h8000_2010, ACC_FETCH, 1'b1, 0, 1'b0);
        set_entry(3,  32'hFFFF_F000, ACC_LOAD,  1'b0, 6, 1'b0);
        // Back-to-back run with the grant held high
        set_entry(4,  32'h1234_5678, ACC_STORE, 1'b0, 0, 1'b1);
        set_entry(5,  32'h2000_0040, ACC_FETCH, 1'b1, 0, 1'b1);
        set_entry(6,  32'h2000_0048, ACC_LOAD,  1'b1, 0, 1'b1);
        set_entry(7,  32'hDEAD_BEE0, ACC_STORE, 1'b0, 0, 1'b1);
        set_entry(8,  32'h0BAD_F00C, ACC_FETCH, 1'b0, 0, 1'b1);
        set_entry(9,  32'h7FFF_FFF8, ACC_LOAD,  1'b1, 0, 1'b1);
        // Long stall fills both FIFOs
        set_entry(10, 32'hA5A5_5A5A, ACC_FETCH, 1'b0, 8, 1'b0);
        set_entry(11, 32'h5A5A_A5A0, ACC_LOAD,  1'b1, 0, 1'b0);
        set_entry(12, 32'h0000_0000, ACC_STORE, 1'b1, 2, 1'b0);
        set_entry(13, 32'hC000_3FF0, ACC_LOAD,  1'b0, 5, 1'b1);
        set_entry(14, 32'h3C3C_C3C0, ACC_FETCH, 1'b1, 0, 1'b1);
        set_entry(15, 32'hFEDC_BA98, ACC_STORE, 1'b0, 0, 1'b1);
    endtask

    // One clock with the output stall stepped on the falling edge
    task automatic run_cycle(output bit taken);
        @(posedge clk);
        taken = in_valid && in_ready;
        @(negedge clk);
        if (stall_left > 0) begin
            stall_left = stall_left - 1;
        end
        out_ready = (stall_left == 0);
    endtask

    //////////////////////////////
    // Port monitor and scoreboard
    //////////////////////////////

    always @(posedge clk) begin
        logic [ADDR_W+2:0]        exp_entry;
        logic [ADDR_W+DATA_W+2:0] cur_out;
        cur_out = {out_addr, out_access, out_walking, out_rdata};
        if (!rst_n) begin
            prev_gnt  = 1'b0;
            addr_wait = 1'b0;
            out_hold  = 1'b0;
        end else begin
            if (in_valid && in_ready) begin
                exp_q.push_back({in_addr, in_access, in_walking});
            end
            if (mem_req && mem_gnt) begin
                gnt_count++;
                if (always_gnt && prev_gnt) begin
                    b2b_count++;
                end
            end
            prev_gnt = mem_req && mem_gnt;
            // Ungranted request keeps its address
            if (addr_wait) begin
                assert (mem_req && (mem_addr == held_addr))
                else report_failure($sformatf("mem_addr_o %h, held %h before grant",
                                              mem_addr, held_addr));
            end
            addr_wait = mem_req && !mem_gnt;
            held_addr = mem_addr;
            // Stalled output stays put
            if (out_hold) begin
                assert (out_valid && (cur_out == held_out))
                else report_failure("out_valid_o dropped or data changed while stalled");
            end
            out_hold = out_valid && !out_ready;
            held_out = cur_out;
            if (out_valid && out_ready) begin
                assert (exp_q.size() > 0)
                else report_failure("output with no matching input");
                exp_entry = exp_q.pop_front();
                assert (out_addr == exp_entry[ADDR_W+2:3])
                else report_failure($sformatf("out_addr_o %h, expected %h",
                                              out_addr, exp_entry[ADDR_W+2:3]));
                assert (out_access == access_type_e'(exp_entry[2:1]))
                else report_failure($sformatf("out_access_o %0d, expected %0d",
                                              out_access, exp_entry[2:1]));
                assert (out_walking == exp_entry[0])
                else report_failure($sformatf("out_walking_o %0b, expected %0b",
                                              out_walking, exp_entry[0]));
                assert (out_rdata == ~exp_entry[ADDR_W+2:3])
                else report_failure($sformatf("out_rdata_o %h, expected %h",
                                              out_rdata, ~exp_entry[ADDR_W+2:3]));
                out_count++;
            end
            // Held transactions at the ports
            assert ((gnt_count - out_count) <= int'(TXN_DEPTH))
            else report_failure($sformatf("%0d transactions outstanding",
                                          gnt_count - out_count));
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin
        bit          taken;
        int unsigned idx;
        in_valid   = 1'b0;
        in_addr    = '0;
        in_access  = ACC_LOAD;
        in_walking = 1'b0;
        out_ready  = 1'b1;
        always_gnt = 1'b0;
        fill_table();
        wait (rst_n == 1'b1);
        @(posedge clk);
        assert (!out_valid && !mem_req && in_ready)
        else report_failure("ports not idle after reset");
        @(negedge clk);
        for (idx = 0; idx < NUM_TXN; idx++) begin
            in_valid   = 1'b1;
            in_addr    = tbl_addr[idx];
            in_access  = tbl_acc[idx];
            in_walking = tbl_walk[idx];
            always_gnt = tbl_agnt[idx];
            // A shorter stall never cuts a running one
            if (tbl_stall[idx] > stall_left) begin
                stall_left = tbl_stall[idx];
                out_ready  = 1'b0;
            end
            taken = 1'b0;
            while (!taken) begin
                run_cycle(taken);
            end
        end
        in_valid = 1'b0;
        // Drain and then look for late extra outputs
        while (out_count < NUM_TXN) begin
            run_cycle(taken);
        end
        repeat (4) run_cycle(taken);
        assert (gnt_count == NUM_TXN)
        else report_failure($sformatf("%0d grants for %0d transactions",
                                      gnt_count, NUM_TXN));
        assert (b2b_count > 0)
        else report_failure("no back-to-back grants in always-grant mode");
        $display("SIMULATION PASSED");
        $finish;
    end

    // Bound on the whole run
    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog expired at time %0t with %0d of %0d transactions done",
                 $time, out_count, NUM_TXN);
        $display("SIMULATION FAILED");
        $fatal(1, "simulation timed out");
    end

endmodule : tb_mem_read_stage

`default_nettype wire
